/* sources.f */
hw/dcache_pkg.sv
hw/dcache_tag_array.sv
hw/dcache_data_array.sv
hw/dcache_ctrl.sv
hw/dcache_top.sv
verif/dcache_mem_model.sv
verif/dcache_tb.sv

/* Bender.yml */
package:
  name: dcache

sources:
  - hw/dcache_pkg.sv
  - hw/dcache_tag_array.sv
  - hw/dcache_data_array.sv
  - hw/dcache_ctrl.sv
  - hw/dcache_top.sv
  - target: simulation
    files:
      - verif/dcache_mem_model.sv
      - verif/dcache_tb.sv

/* verif/dcache_tb.sv */
//####################
// dcache testbench
// random loads and stores against a reference cache model
//####################

`default_nettype none

module dcache_tb
    import dcache_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD     = 20;
    localparam int NUM_REQ        = 600;
    localparam int TIMEOUT_CYCLES = 40;
    localparam int NUM_SLOTS      = 3;

    logic            clk;
    logic            rst_n;
    logic            req_valid;
    dcache_req_t     req;
    logic            ready;
    logic            hit;
    logic [WORD_W-1:0] rdata;
    dcache_mem_req_t mem_req;
    logic            mem_ready;
    dcache_line_t    mem_line;

    // reference model of architectural bytes and tag mirror
    logic [7:0] ref_bytes [NUM_SLOTS][NUM_SETS][16];
    logic       m_valid   [NUM_SETS][NUM_WAYS];
    logic       m_dirty   [NUM_SETS][NUM_WAYS];
    int         m_slot    [NUM_SETS][NUM_WAYS];
    logic       m_lru     [NUM_SETS];

    integer seed;
    int     errors;
    int     exp_wb_count;

    dcache_top i_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .req_valid_i (req_valid),
        .req_i       (req),
        .ready_o     (ready),
        .hit_o       (hit),
        .rdata_o     (rdata),
        .mem_o       (mem_req),
        .mem_ready_i (mem_ready),
        .mem_line_i  (mem_line)
    );

    dcache_mem_model i_mem (
        .clk         (clk),
        .mem_i       (mem_req),
        .mem_ready_o (mem_ready),
        .mem_line_o  (mem_line)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check_value(input string name, input logic [LINE_W-1:0] got,
                               input logic [LINE_W-1:0] exp);
        if (got !== exp) begin
            errors++;
            $display("[ERROR] t=%0t %s = %0h, expected %0h", $time, name, got, exp);
        end
    endtask

    function automatic logic [TAG_W-1:0] tag_of(input int slot);
        case (slot)
            0:       return 25'h000_0012;
            1:       return 25'h000_ab31;
            default: return 25'h1f0_f00c;
        endcase
    endfunction

    function automatic logic [ADDR_W-1:0] line_addr(input int slot, input int set);
        return {tag_of(slot), INDEX_W'(set), 4'b0000};
    endfunction

    function automatic dcache_line_t ref_line(input int slot, input int set);
        dcache_line_t l;
        for (int k = 0; k < 16; k++) l[k*8 +: 8] = ref_bytes[slot][set][k];
        return l;
    endfunction

    // invalid, then clean with way 0 first, then LRU
    function automatic logic pick_victim(input int set);
        if (!m_valid[set][0]) return 1'b0;
        if (!m_valid[set][1]) return 1'b1;
        if (!m_dirty[set][0]) return 1'b0;
        if (!m_dirty[set][1]) return 1'b1;
        return m_lru[set];
    endfunction

    task automatic apply_store(input int slot, input int set, input logic [1:0] block,
                               input logic [1:0] byte_off, input dcache_width_e width,
                               input logic [WORD_W-1:0] wdata);
        int n;
        n = 0;
        if (width == WIDTH_BYTE) n = 1;
        if (width == WIDTH_HALF && byte_off[0] == 1'b0) n = 2;
        if (width == WIDTH_WORD && byte_off == 2'd0) n = 4;
        for (int i = 0; i < n; i++) begin
            ref_bytes[slot][set][block*4 + byte_off + i] = wdata[i*8 +: 8];
        end
    endtask

    task automatic run_request(input int slot, input int set, input logic rw,
                               input logic [1:0] block, input logic [1:0] byte_off,
                               input dcache_width_e width, input logic [WORD_W-1:0] wdata);
        logic              exp_hit;
        logic              way;
        logic              exp_wb;
        logic [ADDR_W-1:0] exp_wb_addr;
        dcache_line_t      exp_wb_line;
        int                cycles;
        logic              wb_seen;
        logic              rd_seen;
        logic              wb_before_rd;
        exp_hit = 1'b0;
        way     = 1'b0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (m_valid[set][w] && m_slot[set][w] == slot) begin
                exp_hit = 1'b1;
                way     = w[0];
            end
        end
        if (!exp_hit) way = pick_victim(set);
        exp_wb      = !exp_hit && m_valid[set][way] && m_dirty[set][way];
        exp_wb_addr = line_addr(m_slot[set][way], set);
        exp_wb_line = ref_line(m_slot[set][way], set);

        @(posedge clk);
        #2;
        req_valid              = 1'b1;
        req.rw                 = rw;
        req.addr.f.tag         = tag_of(slot);
        req.addr.f.index       = INDEX_W'(set);
        req.addr.f.block_off   = block;
        req.addr.f.byte_off    = byte_off;
        req.width              = width;
        req.wdata              = wdata;

        cycles       = 0;
        wb_seen      = 1'b0;
        rd_seen      = 1'b0;
        wb_before_rd = 1'b0;
        do begin
            @(posedge clk);
            #1;
            cycles++;
            if (mem_req.wb) begin
                wb_seen = 1'b1;
                if (exp_wb) begin
                    check_value("mem_o.addr (write-back)", mem_req.addr, exp_wb_addr);
                    check_value("mem_o.line", mem_req.line, exp_wb_line);
                end
            end
            if (mem_req.rd) begin
                rd_seen      = 1'b1;
                wb_before_rd = wb_seen;
                check_value("mem_o.addr (refill)", mem_req.addr, line_addr(slot, set));
            end
        end while (!ready);

        check_value("hit_o", hit, exp_hit);
        check_value("mem_o.wb", wb_seen, exp_wb);
        check_value("mem_o.rd", rd_seen, !exp_hit);
        if (exp_hit) check_value("hit latency", cycles, 1);
        if (exp_wb) check_value("write-back before refill", wb_before_rd, 1'b1);
        if (rw) begin
            check_value("rdata_o", rdata, {ref_bytes[slot][set][block*4 + 3],
                                           ref_bytes[slot][set][block*4 + 2],
                                           ref_bytes[slot][set][block*4 + 1],
                                           ref_bytes[slot][set][block*4]});
        end

        if (exp_wb) exp_wb_count++;
        if (!exp_hit) begin
            m_valid[set][way] = 1'b1;
            m_dirty[set][way] = 1'b0;
            m_slot[set][way]  = slot;
        end
        m_lru[set] = !way;
        if (!rw) begin
            m_dirty[set][way] = 1'b1;   // even a misaligned store
            apply_store(slot, set, block, byte_off, width, wdata);
        end
        #1;
        req_valid = 1'b0;
    endtask

    initial begin
        #(NUM_REQ * TIMEOUT_CYCLES * CLK_PERIOD);
        $display("timeout: the DUT stopped completing requests");
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        int            slot;
        int            set;
        logic          rw;
        logic [1:0]    block;
        logic [1:0]    byte_off;
        dcache_width_e width;
        dcache_line_t  l;
        seed         = 32'he9e5;
        errors       = 0;
        exp_wb_count = 0;
        clk          = 1'b0;
        rst_n        = 1'b0;
        req_valid    = 1'b0;
        req          = '0;
        for (int s = 0; s < NUM_SETS; s++) begin
            m_lru[s] = 1'b0;
            for (int w = 0; w < NUM_WAYS; w++) begin
                m_valid[s][w] = 1'b0;
                m_dirty[s][w] = 1'b0;
                m_slot[s][w]  = 0;
            end
            for (int t = 0; t < NUM_SLOTS; t++) begin
                l = i_mem.line_init(line_addr(t, s));
                for (int k = 0; k < 16; k++) ref_bytes[t][s][k] = l[k*8 +: 8];
            end
        end

        repeat (4) @(posedge clk);
        #2;
        rst_n = 1'b1;
        check_value("ready_o after reset", ready, 1'b0);
        check_value("hit_o after reset", hit, 1'b0);
        check_value("mem_o.rd after reset", mem_req.rd, 1'b0);
        check_value("mem_o.wb after reset", mem_req.wb, 1'b0);

        // first touch of every set
        for (int s = 0; s < NUM_SETS; s++) begin
            run_request(0, s, 1'b1, 2'(s), 2'd0, WIDTH_NONE, '0);
        end

        for (int n = NUM_SETS; n < NUM_REQ; n++) begin
            slot  = $unsigned($random(seed)) % NUM_SLOTS;
            set   = ($random(seed) & 1) ? 5 : 2;
            rw    = $random(seed) & 1;
            width = dcache_width_e'($random(seed) & 3);
            block = $random(seed) & 3;
            case (width)
                WIDTH_HALF: byte_off = ($random(seed) & 1) ? 2'd2 : 2'd0;
                WIDTH_WORD: byte_off = 2'd0;
                default:    byte_off = $random(seed) & 3;
            endcase
            if (($random(seed) & 7) == 0) byte_off = $random(seed) & 3;   // rare misaligned
            run_request(slot, set, rw, block, byte_off, width, $random(seed));
        end

        check_value("write-back count", i_mem.wb_log.size(), exp_wb_count);
        $display("errors: %0d, requests: %0d, write-backs: %0d",
                 errors, NUM_REQ, exp_wb_count);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verif/dcache_mem_model.sv */
//####################
// dcache memory model
// block memory responder with random latency,
// sparse line store and a write-back log
//####################

`default_nettype none

module dcache_mem_model
    import dcache_pkg::*;
(
    input  logic            clk,
    input  dcache_mem_req_t mem_i,
    output logic            mem_ready_o,
    output dcache_line_t    mem_line_o
);

    timeunit 1ns;
    timeprecision 1ps;

    logic [ADDR_W-1:0] store_addr [$];
    dcache_line_t      store_line [$];
    logic [ADDR_W-1:0] wb_log     [$];   // write-back addresses in arrival order

    integer          seed;
    int              lat;
    int              found;
    dcache_mem_req_t cmd;

    // untouched lines hold a hash of their own address
    function automatic dcache_line_t line_init(input logic [ADDR_W-1:0] line_addr);
        dcache_line_t l;
        logic [31:0]  h;
        for (int w = 0; w < 4; w++) begin
            h = (line_addr + w * 4) * 32'h9e37_79b1;
            l[w*32 +: 32] = h ^ (h >> 15);
        end
        return l;
    endfunction

    initial begin
        seed        = 32'he9e5;
        mem_ready_o = 1'b0;
        mem_line_o  = '0;
        @(posedge clk);
        #2;
        forever begin
            if (mem_i.rd || mem_i.wb) begin
                cmd   = mem_i;
                lat   = 1 + ($random(seed) & 3);
                found = -1;
                for (int i = 0; i < store_addr.size(); i++) begin
                    if (store_addr[i] == cmd.addr) found = i;
                end
                repeat (lat - 1) begin
                    @(posedge clk);
                    #2;
                end
                if (cmd.wb) begin
                    wb_log.push_back(cmd.addr);
                    if (found < 0) begin
                        store_addr.push_back(cmd.addr);
                        store_line.push_back(cmd.line);
                    end else begin
                        store_line[found] = cmd.line;
                    end
                end else begin
                    mem_line_o = (found < 0) ? line_init(cmd.addr) : store_line[found];
                end
                mem_ready_o = 1'b1;
                @(posedge clk);
                #2;
                mem_ready_o = 1'b0;   // next strobe may already be up
            end else begin
                @(posedge clk);
                #2;
            end
        end
    end

endmodule

`default_nettype wire

/* hw/dcache_top.sv */
//####################
// dcache top
// controller, tag array and data array
//####################

`default_nettype none

module dcache_top
    import dcache_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              req_valid_i,
    input  dcache_req_t       req_i,
    output logic              ready_o,
    output logic              hit_o,
    output logic [WORD_W-1:0] rdata_o,
    output dcache_mem_req_t   mem_o,
    input  logic              mem_ready_i,
    input  dcache_line_t      mem_line_i
);

    dcache_addr_u       tag_lookup;
    logic               tag_hit;
    logic               tag_hit_way;
    logic               victim_way;
    logic               victim_dirty;
    logic [TAG_W-1:0]   victim_tag;
    logic [INDEX_W-1:0] upd_index;
    logic               upd_way;
    logic               touch;
    logic               fill;
    logic [TAG_W-1:0]   fill_tag;
    logic               set_dirty;
    logic [WORD_W-1:0]  data_rdata;
    dcache_line_t       data_line;
    logic               data_rd_way;
    logic               data_wr_en;
    logic [INDEX_W-1:0] data_wr_index;
    logic               data_wr_way;
    dcache_addr_t       data_wr_addr;
    dcache_width_e      data_wr_width;
    logic [WORD_W-1:0]  data_wr_data;
    logic               data_fill;
    dcache_line_t       data_fill_line;

    dcache_ctrl i_ctrl (
        .clk              (clk),
        .rst_n            (rst_n),
        .req_valid_i      (req_valid_i),
        .req_i            (req_i),
        .ready_o          (ready_o),
        .hit_o            (hit_o),
        .rdata_o          (rdata_o),
        .mem_o            (mem_o),
        .mem_ready_i      (mem_ready_i),
        .mem_line_i       (mem_line_i),
        .tag_lookup_o     (tag_lookup),
        .tag_hit_i        (tag_hit),
        .tag_hit_way_i    (tag_hit_way),
        .victim_way_i     (victim_way),
        .victim_dirty_i   (victim_dirty),
        .victim_tag_i     (victim_tag),
        .upd_index_o      (upd_index),
        .upd_way_o        (upd_way),
        .touch_o          (touch),
        .fill_o           (fill),
        .fill_tag_o       (fill_tag),
        .set_dirty_o      (set_dirty),
        .data_rdata_i     (data_rdata),
        .data_line_i      (data_line),
        .data_rd_way_o    (data_rd_way),
        .data_wr_en_o     (data_wr_en),
        .data_wr_index_o  (data_wr_index),
        .data_wr_way_o    (data_wr_way),
        .data_wr_addr_o   (data_wr_addr),
        .data_wr_width_o  (data_wr_width),
        .data_wr_data_o   (data_wr_data),
        .data_fill_o      (data_fill),
        .data_fill_line_o (data_fill_line)
    );

    dcache_tag_array i_tag_array (
        .clk            (clk),
        .rst_n          (rst_n),
        .lookup_addr_i  (tag_lookup),
        .hit_o          (tag_hit),
        .hit_way_o      (tag_hit_way),
        .victim_way_o   (victim_way),
        .victim_dirty_o (victim_dirty),
        .victim_tag_o   (victim_tag),
        .upd_index_i    (upd_index),
        .upd_way_i      (upd_way),
        .touch_i        (touch),
        .fill_i         (fill),
        .fill_tag_i     (fill_tag),
        .set_dirty_i    (set_dirty)
    );

    // read side follows the lookup address
    dcache_data_array i_data_array (
        .clk            (clk),
        .rd_index_i     (tag_lookup.f.index),
        .rd_way_i       (data_rd_way),
        .rd_block_off_i (tag_lookup.f.block_off),
        .rdata_o        (data_rdata),
        .line_o         (data_line),
        .wr_en_i        (data_wr_en),
        .wr_index_i     (data_wr_index),
        .wr_way_i       (data_wr_way),
        .wr_addr_i      (data_wr_addr),
        .wr_width_i     (data_wr_width),
        .wr_data_i      (data_wr_data),
        .fill_i         (data_fill),
        .fill_line_i    (data_fill_line)
    );

endmodule

`default_nettype wire

/* hw/dcache_ctrl.sv */
//####################
// dcache controller
// lookup, write-back and refill FSM with the miss buffer
//####################

`default_nettype none

module dcache_ctrl
    import dcache_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic               req_valid_i,
    input  dcache_req_t        req_i,
    output logic               ready_o,
    output logic               hit_o,
    output logic [WORD_W-1:0]  rdata_o,
    output dcache_mem_req_t    mem_o,
    input  logic               mem_ready_i,
    input  dcache_line_t       mem_line_i,
    output dcache_addr_u       tag_lookup_o,
    input  logic               tag_hit_i,
    input  logic               tag_hit_way_i,
    input  logic               victim_way_i,
    input  logic               victim_dirty_i,
    input  logic [TAG_W-1:0]   victim_tag_i,
    output logic [INDEX_W-1:0] upd_index_o,
    output logic               upd_way_o,
    output logic               touch_o,
    output logic               fill_o,
    output logic [TAG_W-1:0]   fill_tag_o,
    output logic               set_dirty_o,
    input  logic [WORD_W-1:0]  data_rdata_i,
    input  dcache_line_t       data_line_i,
    output logic               data_rd_way_o,
    output logic               data_wr_en_o,
    output logic [INDEX_W-1:0] data_wr_index_o,
    output logic               data_wr_way_o,
    output dcache_addr_t       data_wr_addr_o,
    output dcache_width_e      data_wr_width_o,
    output logic [WORD_W-1:0]  data_wr_data_o,
    output logic               data_fill_o,
    output dcache_line_t       data_fill_line_o
);

    typedef enum logic [1:0] {
        S_LOOKUP,
        S_WRITE_BACK,
        S_REFILL
    } state_e;

    state_e            state_q;
    dcache_req_t       req_q;      // missing request
    dcache_req_t       cur_req;
    logic              victim_q;
    logic              ready_q;
    logic              hit_q;
    logic [WORD_W-1:0] rdata_q;
    logic              mem_rd_q;
    logic              mem_wb_q;
    logic [ADDR_W-1:0] mem_addr_q;
    dcache_line_t      mem_line_q;

    logic         lookup_go;
    logic         refill_done;
    logic         way_sel;
    dcache_addr_t wb_addr;
    dcache_addr_t rd_addr;

    assign cur_req     = (state_q == S_LOOKUP) ? req_i : req_q;
    assign lookup_go   = (state_q == S_LOOKUP) && req_valid_i && !ready_q; // no re-serve on ready
    assign refill_done = (state_q == S_REFILL) && mem_ready_i;

    always_comb begin
        if (state_q != S_LOOKUP) begin
            way_sel = victim_q;
        end else if (tag_hit_i) begin
            way_sel = tag_hit_way_i;
        end else begin
            way_sel = victim_way_i;
        end
    end

    assign wb_addr = '{tag: victim_tag_i, index: req_i.addr.f.index, default: '0};
    assign rd_addr = '{tag: cur_req.addr.f.tag, index: cur_req.addr.f.index, default: '0};

    assign tag_lookup_o = cur_req.addr;
    assign upd_index_o  = cur_req.addr.f.index;
    assign upd_way_o    = way_sel;
    assign touch_o      = lookup_go && tag_hit_i;
    assign fill_o       = refill_done;
    assign fill_tag_o   = req_q.addr.f.tag;
    assign set_dirty_o  = !cur_req.rw && (touch_o || refill_done); // any store

    assign data_rd_way_o    = way_sel;
    assign data_wr_en_o     = set_dirty_o;
    assign data_wr_index_o  = cur_req.addr.f.index;
    assign data_wr_way_o    = way_sel;
    assign data_wr_addr_o   = cur_req.addr.f;
    assign data_wr_width_o  = cur_req.width;
    assign data_wr_data_o   = cur_req.wdata;
    assign data_fill_o      = refill_done;
    assign data_fill_line_o = mem_line_i;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q  <= S_LOOKUP;
            ready_q  <= 1'b0;
            hit_q    <= 1'b0;
            mem_rd_q <= 1'b0;
            mem_wb_q <= 1'b0;
        end else begin
            ready_q  <= 1'b0;
            hit_q    <= 1'b0;
            mem_rd_q <= 1'b0;
            mem_wb_q <= 1'b0;
            case (state_q)
                S_LOOKUP: begin
                    if (lookup_go) begin
                        if (tag_hit_i) begin
                            ready_q <= 1'b1;
                            hit_q   <= 1'b1;
                        end else if (victim_dirty_i) begin
                            mem_wb_q <= 1'b1;
                            state_q  <= S_WRITE_BACK;
                        end else begin
                            mem_rd_q <= 1'b1;
                            state_q  <= S_REFILL;
                        end
                    end
                end
                S_WRITE_BACK: begin
                    if (mem_ready_i) begin
                        mem_rd_q <= 1'b1;
                        state_q  <= S_REFILL;
                    end
                end
                S_REFILL: begin
                    if (mem_ready_i) begin
                        ready_q <= 1'b1;
                        state_q <= S_LOOKUP;
                    end
                end
                default: state_q <= S_LOOKUP;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (lookup_go) begin
            req_q    <= req_i;
            victim_q <= victim_way_i;
            rdata_q  <= data_rdata_i;
            if (!tag_hit_i) begin
                mem_addr_q <= victim_dirty_i ? wb_addr : rd_addr;
                mem_line_q <= data_line_i;  // victim line
            end
        end
        if (state_q == S_WRITE_BACK && mem_ready_i) begin
            mem_addr_q <= rd_addr;
        end
        if (refill_done) begin
            rdata_q <= mem_line_i[req_q.addr.f.block_off*WORD_W +: WORD_W];
        end
    end

    assign ready_o = ready_q;
    assign hit_o   = hit_q;
    assign rdata_o = rdata_q;
    assign mem_o   = '{rd: mem_rd_q, wb: mem_wb_q, addr: mem_addr_q, line: mem_line_q};

endmodule

`default_nettype wire

/* hw/dcache_data_array.sv */
//####################
// dcache data array
// line storage with byte-lane store merge and word select
//####################

`default_nettype none

module dcache_data_array
    import dcache_pkg::*;
(
    input  logic                   clk,
    input  logic [INDEX_W-1:0]     rd_index_i,
    input  logic                   rd_way_i,
    input  logic [BLOCK_OFF_W-1:0] rd_block_off_i,
    output logic [WORD_W-1:0]      rdata_o,
    output dcache_line_t           line_o,
    input  logic                   wr_en_i,
    input  logic [INDEX_W-1:0]     wr_index_i,
    input  logic                   wr_way_i,
    input  dcache_addr_t           wr_addr_i,
    input  dcache_width_e          wr_width_i,
    input  logic [WORD_W-1:0]      wr_data_i,
    input  logic                   fill_i,
    input  dcache_line_t           fill_line_i
);

    localparam int BYTES_W = WORD_W / 8;

    dcache_line_t data_q [NUM_SETS][NUM_WAYS];

    dcache_line_t        base_line;
    dcache_line_t        new_line;
    logic [BYTES_W-1:0]  be;
    logic [WORD_W-1:0]   wdata_sh;

    assign line_o  = data_q[rd_index_i][rd_way_i];
    assign rdata_o = line_o[rd_block_off_i*WORD_W +: WORD_W];

    // byte enables inside the word are empty when misaligned
    always_comb begin
        be = '0;
        case (wr_width_i)
            WIDTH_BYTE: be = 4'b0001 << wr_addr_i.byte_off;
            WIDTH_HALF: begin
                if (!wr_addr_i.byte_off[0]) begin
                    be = 4'b0011 << wr_addr_i.byte_off;
                end
            end
            WIDTH_WORD: begin
                if (wr_addr_i.byte_off == '0) begin
                    be = 4'b1111;
                end
            end
            default: be = '0;
        endcase
    end

    assign wdata_sh  = wr_data_i << {wr_addr_i.byte_off, 3'b000};
    assign base_line = fill_i ? fill_line_i : data_q[wr_index_i][wr_way_i]; // store lands on refill

    always_comb begin
        new_line = base_line;
        if (wr_en_i) begin
            for (int b = 0; b < BYTES_W; b++) begin
                if (be[b]) begin
                    new_line[wr_addr_i.block_off*WORD_W + b*8 +: 8] = wdata_sh[b*8 +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en_i || fill_i) begin
            data_q[wr_index_i][wr_way_i] <= new_line;
        end
    end

endmodule

`default_nettype wire

/* hw/dcache_tag_array.sv */
//####################
// dcache tag array
// valid, dirty and tag per line, one LRU bit per set,
// hit detection and victim choice
//####################

`default_nettype none

module dcache_tag_array
    import dcache_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  dcache_addr_u       lookup_addr_i,
    output logic               hit_o,
    output logic               hit_way_o,
    output logic               victim_way_o,
    output logic               victim_dirty_o,
    output logic [TAG_W-1:0]   victim_tag_o,
    input  logic [INDEX_W-1:0] upd_index_i,
    input  logic               upd_way_i,
    input  logic               touch_i,
    input  logic               fill_i,
    input  logic [TAG_W-1:0]   fill_tag_i,
    input  logic               set_dirty_i
);

    logic [NUM_SETS-1:0][NUM_WAYS-1:0] valid_q;
    logic [NUM_SETS-1:0][NUM_WAYS-1:0] dirty_q;
    logic [NUM_SETS-1:0]               lru_q;   // least recently used way
    logic [TAG_W-1:0]                  tag_q [NUM_SETS][NUM_WAYS];

    logic [INDEX_W-1:0]  idx;
    logic [NUM_WAYS-1:0] set_valid;
    logic [NUM_WAYS-1:0] set_dirty;
    logic [NUM_WAYS-1:0] way_hit;

    assign idx       = lookup_addr_i.f.index;
    assign set_valid = valid_q[idx];
    assign set_dirty = dirty_q[idx];

    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            way_hit[w] = set_valid[w] && (tag_q[idx][w] == lookup_addr_i.f.tag);
        end
    end

    assign hit_o     = |way_hit;
    assign hit_way_o = way_hit[1];

    // invalid first, then clean (way 0 wins), then LRU
    always_comb begin
        victim_way_o = lru_q[idx];
        if (!set_valid[0]) begin
            victim_way_o = 1'b0;
        end else if (!set_valid[1]) begin
            victim_way_o = 1'b1;
        end else if (!set_dirty[0]) begin
            victim_way_o = 1'b0;
        end else if (!set_dirty[1]) begin
            victim_way_o = 1'b1;
        end
    end

    assign victim_dirty_o = set_valid[victim_way_o] && set_dirty[victim_way_o];
    assign victim_tag_o   = tag_q[idx][victim_way_o];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
            dirty_q <= '0;
            lru_q   <= '0;
        end else begin
            if (fill_i) begin
                valid_q[upd_index_i][upd_way_i] <= 1'b1;
            end
            // a fill clears dirty unless a store merges in the same cycle
            if (fill_i || set_dirty_i) begin
                dirty_q[upd_index_i][upd_way_i] <= set_dirty_i;
            end
            if (touch_i || fill_i) begin
                lru_q[upd_index_i] <= ~upd_way_i;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill_i) begin
            tag_q[upd_index_i][upd_way_i] <= fill_tag_i;
        end
    end

endmodule

`default_nettype wire

/* hw/dcache_pkg.sv */
//####################
// dcache package
// cache geometry, address views and port structs for the
// 2-way 8-set write-back data cache
//####################

`default_nettype none

package dcache_pkg;

    localparam int ADDR_W      = 32;
    localparam int WORD_W      = 32;
    localparam int LINE_W      = 128;
    localparam int NUM_SETS    = 8;
    localparam int NUM_WAYS    = 2;
    localparam int TAG_W       = 25;
    localparam int INDEX_W     = 3;
    localparam int BLOCK_OFF_W = 2;
    localparam int BYTE_OFF_W  = 2;

    // store width codes
    typedef enum logic [1:0] {
        WIDTH_NONE = 2'd0,
        WIDTH_BYTE = 2'd1,  // any byte offset
        WIDTH_HALF = 2'd2,  // byte offset 0 or 2
        WIDTH_WORD = 2'd3   // byte offset 0 only
    } dcache_width_e;

    // | tag | index | block offset | byte offset |
    typedef struct packed {
        logic [TAG_W-1:0]       tag;
        logic [INDEX_W-1:0]     index;
        logic [BLOCK_OFF_W-1:0] block_off;
        logic [BYTE_OFF_W-1:0]  byte_off;
    } dcache_addr_t;

    typedef union packed {
        logic [ADDR_W-1:0] raw;
        dcache_addr_t      f;
    } dcache_addr_u;

    typedef logic [LINE_W-1:0] dcache_line_t;

    // load/store unit request
    typedef struct packed {
        logic              rw;     // 1 read, 0 write
        dcache_addr_u      addr;
        dcache_width_e     width;
        logic [WORD_W-1:0] wdata;
    } dcache_req_t;

    // block memory command
    typedef struct packed {
        logic              rd;
        logic              wb;
        logic [ADDR_W-1:0] addr;   // line aligned
        dcache_line_t      line;   // write-back data
    } dcache_mem_req_t;

endpackage

`default_nettype wire
